// ==== build.f ====
design/bridge_pkg.sv
design/apb_port.sv
design/ctrl_regs.sv
design/link_regs.sv
design/readback_engine.sv
design/bridge_top.sv
test/bridge_checker.sv
test/tb_bridge_top.sv

// ==== test/tb_bridge_top.sv ====
module tb_bridge_top;
	timeunit 1ns;
	timeprecision 100ps;
	import bridge_pkg::*;

	// host addresses
	localparam apb_addr_t A_FUNC    = 20'h00000;
	localparam apb_addr_t A_PORT    = 20'h00004;
	localparam apb_addr_t A_SEL     = 20'h00008;
	localparam apb_addr_t A_STATUS  = 20'h0000C;
	localparam apb_addr_t LINK_BASE = 20'h20000;
	// reference query kinds
	localparam int Q_READ = 0;
	localparam int Q_CTRL = 1;
	localparam int Q_RESP = 2;
	// run length budget
	localparam int N_XFER      = 120;
	localparam int N_RB        = 20;
	localparam int MAX_ACK     = 7;
	localparam int CYCLE_LIMIT = N_XFER * 4 + N_RB * MAX_ACK + 300;

	logic     osc_o = 1'b0;
	logic     rst_n;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	logic     rx_cmd_valid;
	rx_cmd_t  rx_cmd;
	logic     tx_cmd_req;
	tx_cmd_t  tx_cmd;
	logic     tx_cmd_ack;
	logic     lcd_reset;
	logic     dphy_rdy;
	logic     panel_rst;
	logic     pstart;
	logic     link_rst_n;

	// register model
	logic [7:0]  func_m = '0;
	logic [7:0]  port_m = '0;
	logic        sel_m = 1'b0;
	logic        drop_m = 1'b0;
	word_t       tx_m [8] = '{default: '0};
	word_t       rx_m [8] = '{default: '0};
	word_t       resp_q [$];
	logic [31:0] lfsr_state = 32'd97731;
	logic        req_seen;
	int          checks = 0;
	int          errors = 0;
	int          test_mark;
	int          test_num = 0;
	int          cycle_count = 0;

	bridge_top u_dut (.*);

	always #4 osc_o = ~osc_o;

	////////////////////////////////////////////////////////////////////////////
	// random source and reference
	////////////////////////////////////////////////////////////////////////////
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic word_t expected_value(input int what, input apb_addr_t addr,
			input rx_cmd_t cmd);
		word_t r;
		logic  en;
		r = '0;
		case (what)
			Q_READ: begin
				// link window needs bits 9..5 clear
				if (addr[17]) begin
					if (addr[9:5] == '0)
						r = sel_m ? rx_m[addr[4:2]] : tx_m[addr[4:2]];
				end else if (addr[19:4] == '0) begin
					case (addr[3:0])
						4'h0: r = {24'h0, func_m};
						4'h4: r = {24'h0, port_m};
						4'h8: r = {31'h0, sel_m};
						4'hC: r = {26'h0, lcd_reset, dphy_rdy, drop_m, 3'b000};
						default: r = '0;
					endcase
				end
			end
			Q_CTRL: begin
				// panel_rst, pstart and link_rst_n in bits 2..0 gated by func bit 0
				en = func_m[0];
				r = {29'h0, en & port_m[7], en & port_m[1], en & port_m[2]};
			end
			default: begin
				// read response with the id byte picked by the word count and vc from tx word 0
				r = {16'h0, rx_m[0][cmd.word_count[1:0] * 8 +: 8], tx_m[0][1:0], 6'h21};
			end
		endcase
		return r;
	endfunction

	task automatic model_write(input apb_addr_t addr, input word_t data);
		if (addr[17]) begin
			if (addr[9:5] == '0) begin
				if (sel_m)
					rx_m[addr[4:2]] = data;
				else
					tx_m[addr[4:2]] = data;
			end
		end else if (addr[19:4] == '0) begin
			case (addr[3:0])
				4'h0: func_m = data[7:0];
				4'h4: port_m = data[7:0];
				4'h8: sel_m = data[0];
				// any write clears the sticky drop bit
				4'hC: drop_m = 1'b0;
				default: ;
			endcase
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// checks and reporting
	////////////////////////////////////////////////////////////////////////////
	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error: %s = 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic start_test();
		test_num++;
		test_mark = errors;
	endtask

	task automatic end_test(input string name);
		if (errors == test_mark)
			$display("test %0d %s: ok", test_num, name);
		else
			$display("test %0d %s: %0d errors", test_num, name, errors - test_mark);
	endtask

	// compare process on the rising edge
	always @(posedge osc_o) begin
		if (!rst_n) begin
			req_seen = 1'b0;
		end else begin
			if (apb_rsp.ready && !apb_req.write)
				check_value("apb_rsp.rdata", apb_rsp.rdata,
					expected_value(Q_READ, apb_req.addr, '0));
			if (tx_cmd_req && !req_seen) begin
				if (resp_q.size() == 0) begin
					errors++;
					$display("tx_cmd_req rose at %0t with no response expected", $time);
				end else begin
					check_value("tx_cmd", {8'h0, tx_cmd}, resp_q.pop_front());
				end
			end
			req_seen = tx_cmd_req;
		end
	end

	// watchdog
	initial begin
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge osc_o);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("TESTBENCH FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus tasks
	////////////////////////////////////////////////////////////////////////////
	task automatic apb_transfer(input logic wr, input apb_addr_t addr, input word_t data);
		@(negedge osc_o);
		apb_req.sel    = 1'b1;
		apb_req.enable = 1'b0;
		apb_req.write  = wr;
		apb_req.addr   = addr;
		apb_req.wdata  = data;
		@(negedge osc_o);
		apb_req.enable = 1'b1;
		@(negedge osc_o);
		while (!apb_rsp.ready)
			@(negedge osc_o);
		// hold through the edge that completes the access
		@(negedge osc_o);
		apb_req = '0;
		if (wr)
			model_write(addr, data);
	endtask

	task automatic apb_write(input apb_addr_t addr, input word_t data);
		apb_transfer(1'b1, addr, data);
	endtask

	task automatic apb_read(input apb_addr_t addr);
		apb_transfer(1'b0, addr, '0);
	endtask

	task automatic send_cmd(input rx_cmd_t cmd, input logic expect_resp);
		@(negedge osc_o);
		if (expect_resp)
			resp_q.push_back(expected_value(Q_RESP, '0, cmd));
		rx_cmd_valid = 1'b1;
		rx_cmd       = cmd;
		@(negedge osc_o);
		rx_cmd_valid = 1'b0;
	endtask

	// request is due one cycle after the pulse and holds until ack
	task automatic complete_response(input int delay);
		check_value("tx_cmd_req", tx_cmd_req, 1);
		repeat (delay) begin
			@(negedge osc_o);
			check_value("tx_cmd_req", tx_cmd_req, 1);
		end
		tx_cmd_ack = 1'b1;
		@(negedge osc_o);
		tx_cmd_ack = 1'b0;
		check_value("tx_cmd_req", tx_cmd_req, 0);
	endtask

	task automatic expect_no_request();
		repeat (3) @(negedge osc_o);
		check_value("tx_cmd_req", tx_cmd_req, 0);
	endtask

	task automatic set_tx_word0(input logic en, input logic [1:0] vc);
		word_t w;
		w = rand_bits(32);
		w[2] = en;
		w[1:0] = vc;
		apb_write(A_SEL, 32'h0);
		apb_write(LINK_BASE, w);
	endtask

	task automatic check_ctrl();
		@(negedge osc_o);
		check_value("{panel_rst,pstart,link_rst_n}", {29'h0, panel_rst, pstart, link_rst_n},
			expected_value(Q_CTRL, '0, '0));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////
	initial begin
		rx_cmd_t   cmd;
		apb_addr_t oor;
		logic      en;
		logic [1:0] vc;
		int        fails;

		rst_n        = 1'b0;
		apb_req      = '0;
		rx_cmd_valid = 1'b0;
		rx_cmd       = '0;
		tx_cmd_ack   = 1'b0;
		lcd_reset    = 1'b0;
		dphy_rdy     = 1'b0;
		repeat (3) @(negedge osc_o);
		rst_n = 1'b1;

		start_test();
		check_ctrl();
		check_value("tx_cmd_req", tx_cmd_req, 0);
		apb_read(A_FUNC);
		apb_read(A_PORT);
		apb_read(A_SEL);
		apb_read(A_STATUS);
		end_test("reset values");

		start_test();
		apb_write(A_FUNC, 32'h0);
		for (int i = 0; i < 6; i++) begin
			apb_write(A_PORT, rand_bits(8));
			check_ctrl();
		end
		apb_write(A_FUNC, 32'h1);
		for (int i = 0; i < 6; i++) begin
			apb_write(A_PORT, rand_bits(8));
			check_ctrl();
		end
		end_test("function gating");

		start_test();
		for (int b = 0; b < 2; b++) begin
			apb_write(A_SEL, b);
			for (int i = 0; i < 8; i++)
				apb_write(LINK_BASE | apb_addr_t'(i << 2), rand_bits(32));
			// offset above the eight words with bits 9..5 never zero
			oor = LINK_BASE | apb_addr_t'(rand_bits(5) << 5) | apb_addr_t'(rand_bits(3) << 2);
			oor[5] = oor[9:5] == '0 ? 1'b1 : oor[5];
			apb_write(oor, rand_bits(32));
			for (int i = 0; i < 8; i++)
				apb_read(LINK_BASE | apb_addr_t'(i << 2));
			apb_read(oor);
		end
		end_test("link windows");

		start_test();
		for (int i = 0; i < 4; i++) begin
			@(negedge osc_o);
			lcd_reset = i[1];
			dphy_rdy  = i[0];
			apb_read(A_STATUS);
		end
		end_test("status inputs");

		start_test();
		for (int i = 0; i < 12; i++) begin
			en = rand_bits(1);
			vc = rand_bits(2);
			set_tx_word0(en, vc);
			apb_write(A_SEL, 32'h1);
			apb_write(LINK_BASE, rand_bits(32));
			cmd.word_count = 16'(rand_bits(16));
			cmd.vc         = 2'(rand_bits(2));
			cmd.data_type  = 6'h06;
			send_cmd(cmd, en);
			if (en)
				complete_response(rand_bits(3));
			else
				expect_no_request();
		end
		// other data types with respond enable set
		set_tx_word0(1'b1, 2'(rand_bits(2)));
		for (int i = 0; i < 4; i++) begin
			cmd = rx_cmd_t'(rand_bits(24));
			if (cmd.data_type == 6'h06)
				cmd.data_type = 6'h07;
			send_cmd(cmd, 1'b0);
			expect_no_request();
		end
		end_test("dcs read-back");

		start_test();
		set_tx_word0(1'b1, 2'(rand_bits(2)));
		cmd = rx_cmd_t'(rand_bits(24));
		cmd.data_type = 6'h06;
		send_cmd(cmd, 1'b1);
		// second read while the first is pending
		send_cmd(cmd, 1'b0);
		drop_m = 1'b1;
		complete_response(rand_bits(3));
		expect_no_request();
		apb_read(A_STATUS);
		apb_write(A_STATUS, rand_bits(32));
		apb_read(A_STATUS);
		end_test("back-pressure drop");

		if (resp_q.size() != 0) begin
			errors++;
			$display("%0d expected read responses never appeared", resp_q.size());
		end
		@(negedge osc_o);
		fails = u_dut.u_checker.fail_count;
		$display("%0d checks, %0d errors, %0d assertion failures", checks, errors, fails);
		if (errors == 0 && fails == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== test/bridge_checker.sv ====
module bridge_checker (
	input logic                 osc_o,
	input logic                 rst_n,
	input bridge_pkg::apb_req_t apb_req,
	input bridge_pkg::apb_rsp_t apb_rsp,
	input logic                 tx_cmd_req,
	input bridge_pkg::tx_cmd_t  tx_cmd,
	input logic                 tx_cmd_ack
);
	timeunit 1ns;
	timeprecision 100ps;

	// read by the testbench at the end of the run
	int fail_count = 0;

	////////////////////////////////////////////////////////////////////////////
	// APB side
	////////////////////////////////////////////////////////////////////////////
	// ready only in the second access cycle, after setup and one access cycle
	ready_second_access: assert property (@(posedge osc_o) disable iff (!rst_n)
		apb_rsp.ready |-> (apb_req.sel && apb_req.enable)
			&& $past(apb_req.sel && apb_req.enable)
			&& $past(apb_req.sel && !apb_req.enable, 2))
	else begin
		$error("apb ready outside the second access cycle");
		fail_count++;
	end

	////////////////////////////////////////////////////////////////////////////
	// req/ack side
	////////////////////////////////////////////////////////////////////////////
	cmd_stable: assert property (@(posedge osc_o) disable iff (!rst_n)
		(tx_cmd_req && !tx_cmd_ack) |=> $stable(tx_cmd))
	else begin
		$error("tx_cmd changed while waiting for ack");
		fail_count++;
	end

	// handshake cycle ends the request
	req_falls: assert property (@(posedge osc_o) disable iff (!rst_n)
		(tx_cmd_req && tx_cmd_ack) |=> !tx_cmd_req)
	else begin
		$error("tx_cmd_req still high after the handshake cycle");
		fail_count++;
	end

endmodule

bind bridge_top bridge_checker u_checker (
	.osc_o      (osc_o),
	.rst_n      (rst_n),
	.apb_req    (apb_req),
	.apb_rsp    (apb_rsp),
	.tx_cmd_req (tx_cmd_req),
	.tx_cmd     (tx_cmd),
	.tx_cmd_ack (tx_cmd_ack)
);

// ==== design/bridge_top.sv ====
module bridge_top (
	input  logic                osc_o,
	input  logic                rst_n,
	input  bridge_pkg::apb_req_t apb_req,
	output bridge_pkg::apb_rsp_t apb_rsp,
	input  logic                rx_cmd_valid,
	input  bridge_pkg::rx_cmd_t rx_cmd,
	output logic                tx_cmd_req,
	output bridge_pkg::tx_cmd_t tx_cmd,
	input  logic                tx_cmd_ack,
	input  logic                lcd_reset,
	input  logic                dphy_rdy,
	output logic                panel_rst,
	output logic                pstart,
	output logic                link_rst_n
);
	import bridge_pkg::*;

	// bank access
	bank_req_t  bank_req;
	logic       loc_stb;
	logic       tx_stb;
	logic       rx_stb;
	word_t      loc_rdata;
	word_t      tx_rdata;
	word_t      rx_rdata;
	logic [3:0] loc_offset;
	logic       link_offset_ok;
	// control and read-back
	logic       link_sel;
	logic       drop_flag;
	word_t      tx_word0;
	word_t      rx_word0;

	////////////////////////////////////////////////////////////////////////////
	// host side
	////////////////////////////////////////////////////////////////////////////
	apb_port u_apb_port (
		.osc_o          (osc_o),
		.rst_n          (rst_n),
		.apb_req        (apb_req),
		.apb_rsp        (apb_rsp),
		.link_sel       (link_sel),
		.bank_req       (bank_req),
		.loc_stb        (loc_stb),
		.tx_stb         (tx_stb),
		.rx_stb         (rx_stb),
		.loc_rdata      (loc_rdata),
		.tx_rdata       (tx_rdata),
		.rx_rdata       (rx_rdata),
		.loc_offset     (loc_offset),
		.link_offset_ok (link_offset_ok)
	);

	ctrl_regs u_ctrl_regs (
		.osc_o      (osc_o),
		.rst_n      (rst_n),
		.loc_stb    (loc_stb),
		.bank_req   (bank_req),
		.loc_offset (loc_offset),
		.rdata      (loc_rdata),
		.lcd_reset  (lcd_reset),
		.dphy_rdy   (dphy_rdy),
		.drop_flag  (drop_flag),
		.link_sel   (link_sel),
		.panel_rst  (panel_rst),
		.pstart     (pstart),
		.link_rst_n (link_rst_n)
	);

	// transmit link bank
	link_regs u_tx_regs (
		.osc_o     (osc_o),
		.rst_n     (rst_n),
		.stb       (tx_stb),
		.offset_ok (link_offset_ok),
		.bank_req  (bank_req),
		.rdata     (tx_rdata),
		.word0     (tx_word0)
	);

	// receive link bank
	link_regs u_rx_regs (
		.osc_o     (osc_o),
		.rst_n     (rst_n),
		.stb       (rx_stb),
		.offset_ok (link_offset_ok),
		.bank_req  (bank_req),
		.rdata     (rx_rdata),
		.word0     (rx_word0)
	);

	////////////////////////////////////////////////////////////////////////////
	// packet side
	////////////////////////////////////////////////////////////////////////////
	readback_engine u_readback_engine (
		.osc_o        (osc_o),
		.rst_n        (rst_n),
		.rx_cmd_valid (rx_cmd_valid),
		.rx_cmd       (rx_cmd),
		.tx_word0     (tx_word0),
		.rx_word0     (rx_word0),
		.tx_cmd_req   (tx_cmd_req),
		.tx_cmd       (tx_cmd),
		.tx_cmd_ack   (tx_cmd_ack),
		.drop_flag    (drop_flag)
	);

endmodule

// ==== design/readback_engine.sv ====
module readback_engine (
	input  logic                osc_o,
	input  logic                rst_n,
	input  logic                rx_cmd_valid,
	input  bridge_pkg::rx_cmd_t rx_cmd,
	input  bridge_pkg::word_t   tx_word0,
	input  bridge_pkg::word_t   rx_word0,
	output logic                tx_cmd_req,
	output bridge_pkg::tx_cmd_t tx_cmd,
	input  logic                tx_cmd_ack,
	output logic                drop_flag
);
	import bridge_pkg::*;

	rb_state_t state;
	logic      is_dcs_read;
	logic      accept;
	logic      busy_hit;
	logic [7:0] id_byte;

	assign is_dcs_read = rx_cmd_valid && (rx_cmd.data_type == DT_DCS_READ);
	// tx word 0 bit 2 is respond enable
	assign accept      = is_dcs_read && (state == RB_IDLE) && tx_word0[2];
	assign busy_hit    = is_dcs_read && (state == RB_REQ);

	// low two bits of the word count pick the id byte
	assign id_byte = rx_word0[{rx_cmd.word_count[1:0], 3'b000} +: 8];

	////////////////////////////////////////////////////////////////////////////
	// request FSM
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge osc_o) begin
		if (!rst_n) begin
			state <= RB_IDLE;
		end else begin
			case (state)
				RB_IDLE: begin
					if (accept)
						state <= RB_REQ;
				end
				default: begin
					// drop after the handshake cycle
					if (tx_cmd_ack)
						state <= RB_IDLE;
				end
			endcase
		end
	end

	// response fields held until ack
	always_ff @(posedge osc_o) begin
		if (!rst_n) begin
			tx_cmd <= '0;
		end else if (accept) begin
			tx_cmd.vc         <= tx_word0[1:0];
			tx_cmd.data_type  <= DT_READ_RESP;
			tx_cmd.word_count <= {8'h00, id_byte};
		end
	end

	// single pulse per lost read
	always_ff @(posedge osc_o) begin
		if (!rst_n)
			drop_flag <= 1'b0;
		else
			drop_flag <= busy_hit;
	end

	assign tx_cmd_req = (state == RB_REQ);

endmodule

// ==== design/link_regs.sv ====
module link_regs (
	input  logic                  osc_o,
	input  logic                  rst_n,
	input  logic                  stb,
	input  logic                  offset_ok,
	input  bridge_pkg::bank_req_t bank_req,
	output bridge_pkg::word_t     rdata,
	output bridge_pkg::word_t     word0
);
	import bridge_pkg::*;

	word_t regs [8];
	logic  hit;

	// offsets outside the eight words are dead
	assign hit = stb && offset_ok;

	////////////////////////////////////////////////////////////////////////////
	// register file
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge osc_o) begin
		if (!rst_n) begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end else if (hit && bank_req.write) begin
			regs[bank_req.index] <= bank_req.wdata;
		end
	end

	// read port, zero when not addressed
	always_ff @(posedge osc_o) begin
		if (!rst_n)
			rdata <= '0;
		else if (hit)
			rdata <= regs[bank_req.index];
		else
			rdata <= '0;
	end

	// word 0 feeds the read-back engine
	assign word0 = regs[0];

endmodule

// ==== design/ctrl_regs.sv ====
module ctrl_regs (
	input  logic                  osc_o,
	input  logic                  rst_n,
	input  logic                  loc_stb,
	input  bridge_pkg::bank_req_t bank_req,
	input  logic [3:0]            loc_offset,
	output bridge_pkg::word_t     rdata,
	input  logic                  lcd_reset,
	input  logic                  dphy_rdy,
	input  logic                  drop_flag,
	output logic                  link_sel,
	output logic                  panel_rst,
	output logic                  pstart,
	output logic                  link_rst_n
);
	import bridge_pkg::*;

	logic [7:0] func_q;
	logic [7:0] port_q;
	logic       drop_q;
	logic       wr_en;
	word_t      status;
	word_t      rd_word;

	assign wr_en = loc_stb && bank_req.write;

	// status from live pins plus sticky drop
	always_comb begin
		status                     = '0;
		status[STAT_LCD_RESET_BIT] = lcd_reset;
		status[STAT_DPHY_RDY_BIT]  = dphy_rdy;
		status[STAT_DROP_BIT]      = drop_q;
	end

	always_comb begin
		case (loc_offset)
			LOC_FUNC:   rd_word = {24'h0, func_q};
			LOC_PORT:   rd_word = {24'h0, port_q};
			LOC_SEL:    rd_word = {31'h0, link_sel};
			LOC_STATUS: rd_word = status;
			default:    rd_word = '0;
		endcase
	end

	always_ff @(posedge osc_o) begin
		if (!rst_n) begin
			func_q     <= '0;
			port_q     <= '0;
			link_sel   <= 1'b0;
			drop_q     <= 1'b0;
			rdata      <= '0;
			panel_rst  <= 1'b0;
			pstart     <= 1'b0;
			link_rst_n <= 1'b0;
		end else begin
			if (wr_en && loc_offset == LOC_FUNC)
				func_q <= bank_req.wdata[7:0];
			if (wr_en && loc_offset == LOC_PORT)
				port_q <= bank_req.wdata[7:0];
			if (wr_en && loc_offset == LOC_SEL)
				link_sel <= bank_req.wdata[0];
			// a new drop wins over the clearing write
			if (drop_flag)
				drop_q <= 1'b1;
			else if (wr_en && loc_offset == LOC_STATUS)
				drop_q <= 1'b0;
			rdata <= loc_stb ? rd_word : '0;
			// func bit 0 enables all three controls
			panel_rst  <= func_q[0] && port_q[PORT_PANEL_RST_BIT];
			pstart     <= func_q[0] && port_q[PORT_START_BIT];
			link_rst_n <= func_q[0] && port_q[PORT_LINK_RST_BIT];
		end
	end

endmodule

// ==== design/apb_port.sv ====
module apb_port (
	input  logic                  osc_o,
	input  logic                  rst_n,
	input  bridge_pkg::apb_req_t  apb_req,
	output bridge_pkg::apb_rsp_t  apb_rsp,
	input  logic                  link_sel,
	output bridge_pkg::bank_req_t bank_req,
	output logic                  loc_stb,
	output logic                  tx_stb,
	output logic                  rx_stb,
	input  bridge_pkg::word_t     loc_rdata,
	input  bridge_pkg::word_t     tx_rdata,
	input  bridge_pkg::word_t     rx_rdata,
	output logic [3:0]            loc_offset,
	output logic                  link_offset_ok
);
	import bridge_pkg::*;

	apb_state_t state;
	logic       start;
	logic       link_win;
	logic       loc_hit;
	logic [2:0] rd_pick;
	word_t      rd_mux;

	// setup cycle seen while idle
	assign start    = (state == APB_IDLE) && apb_req.sel && !apb_req.enable;
	assign link_win = apb_req.addr[LINK_WIN_BIT];
	// local window is the low nibble only, anything above must be clear
	assign loc_hit  = (apb_req.addr[$bits(apb_addr_t)-1:4] == '0);

	always_ff @(posedge osc_o) begin
		if (!rst_n) begin
			state <= APB_IDLE;
		end else begin
			case (state)
				APB_IDLE:  state <= start ? APB_WAIT : APB_IDLE;
				APB_WAIT:  state <= APB_READY;
				default:   state <= APB_IDLE;
			endcase
		end
	end

	// one strobe in the first access cycle
	always_ff @(posedge osc_o) begin
		if (!rst_n) begin
			loc_stb <= 1'b0;
			tx_stb  <= 1'b0;
			rx_stb  <= 1'b0;
			rd_pick <= '0;
		end else begin
			loc_stb <= start && loc_hit;
			tx_stb  <= start && link_win && !link_sel;
			rx_stb  <= start && link_win && link_sel;
			// remember the bank for the ready cycle
			if (state == APB_WAIT)
				rd_pick <= {rx_stb, tx_stb, loc_stb};
		end
	end

	// address and data for the bank
	always_ff @(posedge osc_o) begin
		if (start) begin
			bank_req.write <= apb_req.write;
			bank_req.index <= apb_req.addr[4:2];
			bank_req.wdata <= apb_req.wdata;
			loc_offset     <= apb_req.addr[3:0];
			link_offset_ok <= (apb_req.addr[LINK_OFFSET_BITS-1:5] == '0);
		end
	end

	// no hit reads as zero
	always_comb begin
		case (rd_pick)
			3'b001:  rd_mux = loc_rdata;
			3'b010:  rd_mux = tx_rdata;
			3'b100:  rd_mux = rx_rdata;
			default: rd_mux = '0;
		endcase
	end

	assign apb_rsp.ready = (state == APB_READY);
	assign apb_rsp.rdata = apb_rsp.ready ? rd_mux : '0;

endmodule

// ==== design/bridge_pkg.sv ====
package bridge_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////////////////////
	typedef logic [31:0] word_t;
	typedef logic [19:0] apb_addr_t;
	typedef logic [1:0]  vc_t;
	typedef logic [5:0]  data_type_t;
	typedef logic [15:0] byte_count_t;
	typedef logic [2:0]  reg_index_t;

	////////////////////////////////////////////////////////////////////////////
	// bus and packet structs
	////////////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic      sel;
		logic      enable;
		logic      write;
		apb_addr_t addr;
		word_t     wdata;
	} apb_req_t;

	typedef struct packed {
		logic  ready;
		word_t rdata;
	} apb_rsp_t;

	// one access toward a register bank
	typedef struct packed {
		logic       write;
		reg_index_t index;
		word_t      wdata;
	} bank_req_t;

	// packet header, word count on top and data id in the low byte
	typedef struct packed {
		byte_count_t word_count;
		vc_t         vc;
		data_type_t  data_type;
	} rx_cmd_t;

	typedef struct packed {
		byte_count_t word_count;
		vc_t         vc;
		data_type_t  data_type;
	} tx_cmd_t;

	typedef enum logic [1:0] {APB_IDLE, APB_WAIT, APB_READY} apb_state_t;
	typedef enum logic {RB_IDLE, RB_REQ} rb_state_t;

	////////////////////////////////////////////////////////////////////////////
	// register map
	////////////////////////////////////////////////////////////////////////////
	localparam int LINK_WIN_BIT     = 17;
	localparam int LINK_OFFSET_BITS = 10;

	localparam logic [3:0] LOC_FUNC   = 4'h0;
	localparam logic [3:0] LOC_PORT   = 4'h4;
	localparam logic [3:0] LOC_SEL    = 4'h8;
	localparam logic [3:0] LOC_STATUS = 4'hC;

	localparam data_type_t DT_DCS_READ  = 6'h06;
	localparam data_type_t DT_READ_RESP = 6'h21;

	// port register bits
	localparam int PORT_START_BIT     = 1;
	localparam int PORT_LINK_RST_BIT  = 2;
	localparam int PORT_PANEL_RST_BIT = 7;

	// status register bits
	localparam int STAT_LCD_RESET_BIT = 5;
	localparam int STAT_DPHY_RDY_BIT  = 4;
	localparam int STAT_DROP_BIT      = 3;

endpackage
